// File: lsq_cfg.svh
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

// queue geometry
`define LSQ_DEPTH 8
`define LSQ_IDX_W 3

// tag and datapath widths
`define ROB_TAG_W 5
`define PREG_W    7
`define XLEN      32

`endif

// File: lsq_entry_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_cfg.svh"

interface lsq_entry_if;

    // snapshot of the registered queue
    lsq_types_pkg::lsq_entry_t entries [`LSQ_DEPTH];
    logic [`LSQ_IDX_W-1:0]     head_idx;

    // one load resolved this cycle
    logic                      load_done;
    logic [`LSQ_IDX_W-1:0]     load_done_idx;

    modport queue_side (
        output entries, head_idx,
        input  load_done, load_done_idx
    );

    modport resolver_side (
        input  entries, head_idx,
        output load_done, load_done_idx
    );

endinterface

`default_nettype wire

// File: lsq_forward_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_cfg.svh"

module lsq_forward_check (
    input  lsq_types_pkg::lsq_entry_t      entries [`LSQ_DEPTH],
    input  logic [`LSQ_IDX_W-1:0]          head_idx,
    input  logic [`LSQ_IDX_W-1:0]          load_idx,
    output lsq_types_pkg::load_decision_e  decision,
    output logic [`XLEN-1:0]               fwd_data
);

    lsq_types_pkg::lsq_entry_t ld;
    lsq_types_pkg::lsq_entry_t st;
    logic [`LSQ_IDX_W-1:0]     load_age;
    logic [`LSQ_IDX_W-1:0]     idx;
    logic [`XLEN:0]            ld_lo;
    logic [`XLEN:0]            ld_hi;
    logic [`XLEN:0]            st_lo;
    logic [`XLEN:0]            st_hi;
    logic [1:0]                lane;
    logic                      found;

    function automatic logic [2:0] size_bytes(input lsq_types_pkg::mem_size_e s);
        case (s)
            lsq_types_pkg::SIZE_BYTE: return 3'd1;
            lsq_types_pkg::SIZE_HALF: return 3'd2;
            default:                  return 3'd4;
        endcase
    endfunction

    always_comb begin
        decision = lsq_types_pkg::DEC_MEMORY;
        fwd_data = '0;
        found    = 1'b0;
        ld       = entries[load_idx];
        // number of entries older than the load
        load_age = load_idx - head_idx;
        ld_lo    = {1'b0, ld.addr};
        ld_hi    = ld_lo + size_bytes(ld.size);
        idx      = '0;
        st       = '0;
        st_lo    = '0;
        st_hi    = '0;
        lane     = '0;

        // walk from the closest older entry back to the head
        for (int k = 1; k < `LSQ_DEPTH; k++) begin
            idx   = load_idx - `LSQ_IDX_W'(k);
            st    = entries[idx];
            st_lo = {1'b0, st.addr};
            st_hi = st_lo + size_bytes(st.size);
            lane  = ld.addr[1:0] - st.addr[1:0];
            if (!found && k <= int'(load_age)) begin
                if (!st.issued) begin
                    // unknown address ahead, hold the load
                    found    = 1'b1;
                    decision = lsq_types_pkg::DEC_WAIT;
                end else if (st.is_store && ld_lo < st_hi && st_lo < ld_hi) begin
                    found = 1'b1;
                    if (ld.size == lsq_types_pkg::SIZE_WORD &&
                        st.size == lsq_types_pkg::SIZE_WORD &&
                        ld.addr == st.addr) begin
                        decision = lsq_types_pkg::DEC_FORWARD;
                        fwd_data = st.data;
                    end else if (ld.size == lsq_types_pkg::SIZE_BYTE) begin
                        // lbu, zero extended
                        decision = lsq_types_pkg::DEC_FORWARD;
                        fwd_data = {{(`XLEN-8){1'b0}}, st.data[{lane, 3'b000} +: 8]};
                    end else begin
                        // partial cover, wait for the store to drain
                        decision = lsq_types_pkg::DEC_WAIT;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: lsq_load_resolver.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_cfg.svh"

module lsq_load_resolver (
    input  logic                      clk,
    input  logic                      reset,
    lsq_entry_if.resolver_side        ent,
    output logic                      load_fwd_valid,
    output logic [`XLEN-1:0]          load_fwd_data,
    output logic                      load_mem,
    output logic [`XLEN-1:0]          load_mem_addr,
    output lsq_types_pkg::mem_size_e  load_mem_size,
    output logic [`PREG_W-1:0]        load_pd,
    output logic [`ROB_TAG_W-1:0]     load_rob_tag
);

    lsq_types_pkg::load_decision_e decision;
    lsq_types_pkg::lsq_entry_t     pick_ent;
    logic [`LSQ_IDX_W-1:0]         pick_idx;
    logic [`LSQ_IDX_W-1:0]         scan_idx;
    logic [`XLEN-1:0]              fwd_data;
    logic                          pick_valid;

    // oldest issued load not yet resolved
    always_comb begin
        pick_valid = 1'b0;
        pick_idx   = '0;
        scan_idx   = '0;
        for (int k = 0; k < `LSQ_DEPTH; k++) begin
            scan_idx = ent.head_idx + `LSQ_IDX_W'(k);
            if (!pick_valid && ent.entries[scan_idx].valid && ent.entries[scan_idx].issued &&
                !ent.entries[scan_idx].is_store && !ent.entries[scan_idx].done) begin
                pick_valid = 1'b1;
                pick_idx   = scan_idx;
            end
        end
    end

    assign pick_ent = ent.entries[pick_idx];

    lsq_forward_check u_fwd_check (
        .entries  (ent.entries),
        .head_idx (ent.head_idx),
        .load_idx (pick_idx),
        .decision (decision),
        .fwd_data (fwd_data)
    );

    // queue marks done on the same edge the outputs pulse
    assign ent.load_done     = pick_valid && (decision != lsq_types_pkg::DEC_WAIT);
    assign ent.load_done_idx = pick_idx;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_fwd_valid <= 1'b0;
            load_fwd_data  <= '0;
            load_mem       <= 1'b0;
            load_mem_addr  <= '0;
            load_mem_size  <= lsq_types_pkg::SIZE_BYTE;
            load_pd        <= '0;
            load_rob_tag   <= '0;
        end else begin
            load_fwd_valid <= ent.load_done && (decision == lsq_types_pkg::DEC_FORWARD);
            load_mem       <= ent.load_done && (decision == lsq_types_pkg::DEC_MEMORY);
            if (ent.load_done) begin
                load_pd      <= pick_ent.pd;
                load_rob_tag <= pick_ent.rob_tag;
                if (decision == lsq_types_pkg::DEC_FORWARD) begin
                    load_fwd_data <= fwd_data;
                end else begin
                    load_mem_addr <= pick_ent.addr;
                    load_mem_size <= pick_ent.size;
                end
            end
        end
    end

    a_one_source: assert property (@(posedge clk) disable iff (reset)
        !(load_fwd_valid && load_mem));

endmodule

`default_nettype wire

// File: lsq_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_cfg.svh"

module lsq_queue (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       dispatch_valid,
    input  logic [`ROB_TAG_W-1:0]      dispatch_rob_tag,
    input  logic                       issue_valid,
    input  rv_isa_pkg::rv_opcode_e     issue_opcode,
    input  rv_isa_pkg::rv_func3_e      issue_func3,
    input  logic [`ROB_TAG_W-1:0]      issue_rob_tag,
    input  logic [`PREG_W-1:0]         issue_pd,
    input  logic [`XLEN-1:0]           issue_base,
    input  logic [`XLEN-1:0]           issue_imm,
    input  logic [`XLEN-1:0]           issue_store_data,
    input  logic                       retire_valid,
    input  logic [`ROB_TAG_W-1:0]      rob_head,
    output logic                       queue_full,
    output logic                       store_issued,
    output logic [`ROB_TAG_W-1:0]      store_issued_tag,
    output logic                       store_wb,
    output logic [`XLEN-1:0]           store_wb_addr,
    output logic [`XLEN-1:0]           store_wb_data,
    output lsq_types_pkg::mem_size_e   store_wb_size,
    lsq_entry_if.queue_side            ent
);

    lsq_types_pkg::lsq_entry_t slots [`LSQ_DEPTH];
    lsq_types_pkg::lsq_entry_t head;
    lsq_types_pkg::mem_size_e  issue_size;
    logic [`LSQ_IDX_W-1:0]     w_ptr;
    logic [`LSQ_IDX_W-1:0]     head_ptr;
    logic [`LSQ_IDX_W-1:0]     issue_idx;
    logic                      issue_hit;
    logic                      issue_is_store;
    logic                      retire_ok;
    logic                      dup_tag;

    assign ent.entries  = slots;
    assign ent.head_idx = head_ptr;

    assign head           = slots[head_ptr];
    assign issue_is_store = (issue_opcode == rv_isa_pkg::OP_STORE);

    // loads must be resolved before they may leave
    assign retire_ok = retire_valid && head.valid && head.issued &&
                       (head.rob_tag == rob_head) && (head.is_store || head.done);

    always_comb begin
        case (issue_func3)
            rv_isa_pkg::F3_BYTE_U: issue_size = lsq_types_pkg::SIZE_BYTE;
            rv_isa_pkg::F3_HALF:   issue_size = lsq_types_pkg::SIZE_HALF;
            default:               issue_size = lsq_types_pkg::SIZE_WORD;
        endcase
    end

    // full flag and tag match for the issue bus
    always_comb begin
        queue_full = 1'b1;
        issue_hit  = 1'b0;
        issue_idx  = '0;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (!slots[i].valid) begin
                queue_full = 1'b0;
            end
            if (issue_valid && slots[i].valid && !slots[i].issued &&
                slots[i].rob_tag == issue_rob_tag) begin
                issue_hit = 1'b1;
                issue_idx = `LSQ_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `LSQ_DEPTH; i++) begin
                slots[i] <= '0;
            end
            w_ptr            <= '0;
            head_ptr         <= '0;
            store_issued     <= 1'b0;
            store_issued_tag <= '0;
            store_wb         <= 1'b0;
            store_wb_addr    <= '0;
            store_wb_data    <= '0;
            store_wb_size    <= lsq_types_pkg::SIZE_BYTE;
        end else begin
            store_issued <= issue_hit && issue_is_store;
            store_wb     <= retire_ok && head.is_store;

            // in-order allocation, dropped when full
            if (dispatch_valid && !queue_full) begin
                slots[w_ptr].valid    <= 1'b1;
                slots[w_ptr].issued   <= 1'b0;
                slots[w_ptr].is_store <= 1'b0;
                slots[w_ptr].done     <= 1'b0;
                slots[w_ptr].rob_tag  <= dispatch_rob_tag;
                w_ptr                 <= w_ptr + 1'b1;
            end

            if (issue_hit) begin
                slots[issue_idx].issued   <= 1'b1;
                slots[issue_idx].is_store <= issue_is_store;
                slots[issue_idx].size     <= issue_size;
                slots[issue_idx].pd       <= issue_pd;
                slots[issue_idx].addr     <= issue_base + issue_imm;
                slots[issue_idx].data     <= issue_store_data;
                if (issue_is_store) begin
                    store_issued_tag <= issue_rob_tag;
                end
            end

            if (ent.load_done) begin
                slots[ent.load_done_idx].done <= 1'b1;
            end

            if (retire_ok) begin
                slots[head_ptr].valid  <= 1'b0;
                slots[head_ptr].issued <= 1'b0;
                slots[head_ptr].done   <= 1'b0;
                head_ptr               <= head_ptr + 1'b1;
                if (head.is_store) begin
                    store_wb_addr <= head.addr;
                    store_wb_data <= head.data;
                    store_wb_size <= head.size;
                end
            end
        end
    end

    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            for (int j = i + 1; j < `LSQ_DEPTH; j++) begin
                if (slots[i].valid && slots[j].valid &&
                    slots[i].rob_tag == slots[j].rob_tag) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    a_unique_tags: assert property (@(posedge clk) disable iff (reset) !dup_tag);

    // a slot only empties after it was issued
    for (genvar g = 0; g < `LSQ_DEPTH; g++) begin : g_free_chk
        a_free_issued: assert property (@(posedge clk) disable iff (reset)
            $fell(slots[g].valid) |-> $past(slots[g].issued));
    end

    a_done_is_load: assert property (@(posedge clk) disable iff (reset)
        ent.load_done |-> slots[ent.load_done_idx].valid &&
                          !slots[ent.load_done_idx].is_store);

endmodule

`default_nettype wire

// File: lsq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_cfg.svh"

module lsq_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    dispatch_valid,
    input  logic [`ROB_TAG_W-1:0]   dispatch_rob_tag,
    input  logic                    issue_valid,
    input  rv_isa_pkg::rv_opcode_e  issue_opcode,
    input  rv_isa_pkg::rv_func3_e   issue_func3,
    input  logic [`ROB_TAG_W-1:0]   issue_rob_tag,
    input  logic [`PREG_W-1:0]      issue_pd,
    input  logic [`XLEN-1:0]        issue_base,
    input  logic [`XLEN-1:0]        issue_imm,
    input  logic [`XLEN-1:0]        issue_store_data,
    input  logic                    retire_valid,
    input  logic [`ROB_TAG_W-1:0]   rob_head,
    output logic                    queue_full,
    output logic                    store_issued,
    output logic [`ROB_TAG_W-1:0]   store_issued_tag,
    output logic                    store_wb,
    output logic [`XLEN-1:0]        store_wb_addr,
    output logic [`XLEN-1:0]        store_wb_data,
    output logic [1:0]              store_wb_size,
    output logic                    load_fwd_valid,
    output logic [`XLEN-1:0]        load_fwd_data,
    output logic                    load_mem,
    output logic [`XLEN-1:0]        load_mem_addr,
    output logic [1:0]              load_mem_size,
    output logic [`PREG_W-1:0]      load_pd,
    output logic [`ROB_TAG_W-1:0]   load_rob_tag
);

    // queue snapshot and load-done return path
    lsq_entry_if ent_if ();

    lsq_queue u_queue (
        .clk              (clk),
        .reset            (reset),
        .dispatch_valid   (dispatch_valid),
        .dispatch_rob_tag (dispatch_rob_tag),
        .issue_valid      (issue_valid),
        .issue_opcode     (issue_opcode),
        .issue_func3      (issue_func3),
        .issue_rob_tag    (issue_rob_tag),
        .issue_pd         (issue_pd),
        .issue_base       (issue_base),
        .issue_imm        (issue_imm),
        .issue_store_data (issue_store_data),
        .retire_valid     (retire_valid),
        .rob_head         (rob_head),
        .queue_full       (queue_full),
        .store_issued     (store_issued),
        .store_issued_tag (store_issued_tag),
        .store_wb         (store_wb),
        .store_wb_addr    (store_wb_addr),
        .store_wb_data    (store_wb_data),
        .store_wb_size    (store_wb_size),
        .ent              (ent_if.queue_side)
    );

    lsq_load_resolver u_resolver (
        .clk            (clk),
        .reset          (reset),
        .ent            (ent_if.resolver_side),
        .load_fwd_valid (load_fwd_valid),
        .load_fwd_data  (load_fwd_data),
        .load_mem       (load_mem),
        .load_mem_addr  (load_mem_addr),
        .load_mem_size  (load_mem_size),
        .load_pd        (load_pd),
        .load_rob_tag   (load_rob_tag)
    );

endmodule

`default_nettype wire

// File: lsq_types_pkg.sv
`default_nettype none

`include "lsq_cfg.svh"

package lsq_types_pkg;

    // access size kept per entry
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // outcome of one load against the older entries
    typedef enum logic [1:0] {
        DEC_WAIT    = 2'd0,
        DEC_FORWARD = 2'd1,
        DEC_MEMORY  = 2'd2
    } load_decision_e;

    typedef struct packed {
        logic                  valid;
        logic                  issued;
        logic                  is_store;
        mem_size_e             size;
        logic [`ROB_TAG_W-1:0] rob_tag;
        logic [`PREG_W-1:0]    pd;
        logic [`XLEN-1:0]      addr;
        // store data, unused for loads
        logic [`XLEN-1:0]      data;
        // load already resolved
        logic                  done;
    } lsq_entry_t;

endpackage

`default_nettype wire

// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // major opcodes seen by the memory pipe
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } rv_opcode_e;

    // width field of loads and stores
    // only lbu, sh and sw/lw are supported
    typedef enum logic [2:0] {
        F3_HALF   = 3'b001,
        F3_WORD   = 3'b010,
        F3_BYTE_U = 3'b100
    } rv_func3_e;

endpackage

`default_nettype wire

// File: sources.f
+incdir+.
rv_isa_pkg.sv
lsq_types_pkg.sv
lsq_entry_if.sv
lsq_queue.sv
lsq_forward_check.sv
lsq_load_resolver.sv
lsq_top.sv
tb_clock_gen.sv
tb_lsq.sv

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // 20 ns period
    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

endmodule

`default_nettype wire

// File: tb_lsq.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_cfg.svh"

module tb_lsq;

    localparam int WAIT_LIMIT = 50;

    logic                        clk;
    logic                        reset;
    logic                        dispatch_valid;
    logic [`ROB_TAG_W-1:0]       dispatch_rob_tag;
    logic                        issue_valid;
    rv_isa_pkg::rv_opcode_e      issue_opcode;
    rv_isa_pkg::rv_func3_e       issue_func3;
    logic [`ROB_TAG_W-1:0]       issue_rob_tag;
    logic [`PREG_W-1:0]          issue_pd;
    logic [`XLEN-1:0]            issue_base;
    logic [`XLEN-1:0]            issue_imm;
    logic [`XLEN-1:0]            issue_store_data;
    logic                        retire_valid;
    logic [`ROB_TAG_W-1:0]       rob_head;
    logic                        queue_full;
    logic                        store_issued;
    logic [`ROB_TAG_W-1:0]       store_issued_tag;
    logic                        store_wb;
    logic [`XLEN-1:0]            store_wb_addr;
    logic [`XLEN-1:0]            store_wb_data;
    logic [1:0]                  store_wb_size;
    logic                        load_fwd_valid;
    logic [`XLEN-1:0]            load_fwd_data;
    logic                        load_mem;
    logic [`XLEN-1:0]            load_mem_addr;
    logic [1:0]                  load_mem_size;
    logic [`PREG_W-1:0]          load_pd;
    logic [`ROB_TAG_W-1:0]       load_rob_tag;

    logic [31:0]                 lfsr;
    logic [`ROB_TAG_W-1:0]       next_tag;
    int                          check_count;
    int                          error_count;
    int                          timeout_count;

    tb_clock_gen clock_gen (.clk(clk));

    lsq_top dut (.*);

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [`XLEN-1:0] rand_bits(input int n);
        logic [`XLEN-1:0] r;
        logic             fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[`XLEN-2:0], fb};
        end
        return r;
    endfunction

    function automatic logic [`XLEN-1:0] word_addr();
        return rand_bits(`XLEN - 2) << 2;
    endfunction

    task automatic check_data(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_tag(input string name, input logic [`ROB_TAG_W-1:0] exp,
                             input logic [`ROB_TAG_W-1:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_size(input string name, input lsq_types_pkg::mem_size_e exp,
                              input lsq_types_pkg::mem_size_e act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // every drive task starts and ends on a falling edge
    task automatic dispatch_entry(output logic [`ROB_TAG_W-1:0] tag);
        tag              = next_tag;
        next_tag         = next_tag + 1'b1;
        dispatch_valid   = 1'b1;
        dispatch_rob_tag = tag;
        @(negedge clk);
        dispatch_valid   = 1'b0;
    endtask

    task automatic issue_op(input rv_isa_pkg::rv_opcode_e op, input rv_isa_pkg::rv_func3_e f3,
                            input logic [`ROB_TAG_W-1:0] tag, input logic [`PREG_W-1:0] pd,
                            input logic [`XLEN-1:0] base, input logic [`XLEN-1:0] imm,
                            input logic [`XLEN-1:0] data);
        issue_valid      = 1'b1;
        issue_opcode     = op;
        issue_func3      = f3;
        issue_rob_tag    = tag;
        issue_pd         = pd;
        issue_base       = base;
        issue_imm        = imm;
        issue_store_data = data;
        @(negedge clk);
        issue_valid      = 1'b0;
    endtask

    task automatic retire_entry(input logic [`ROB_TAG_W-1:0] tag);
        retire_valid = 1'b1;
        rob_head     = tag;
        @(negedge clk);
        retire_valid = 1'b0;
    endtask

    // waits for either load response and leaves seen low on timeout
    task automatic wait_load(input string name, output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            seen = load_fwd_valid || load_mem;
            n++;
        end
        if (!seen) begin
            error_count++;
            timeout_count++;
            $display("%s: no load response arrived before the timeout", name);
        end
    endtask

    task automatic expect_no_load(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_data({name, " quiet"}, '0, `XLEN'({load_fwd_valid, load_mem}));
        end
    endtask

    task automatic expect_fwd(input string name, input logic [`XLEN-1:0] data,
                              input logic [`PREG_W-1:0] pd, input logic [`ROB_TAG_W-1:0] tag);
        bit seen;
        wait_load(name, seen);
        if (seen) begin
            check_data({name, " fwd_valid"}, 1, `XLEN'(load_fwd_valid));
            check_data({name, " mem"}, 0, `XLEN'(load_mem));
            check_data({name, " data"}, data, load_fwd_data);
            check_data({name, " pd"}, `XLEN'(pd), `XLEN'(load_pd));
            check_tag({name, " tag"}, tag, load_rob_tag);
        end
    endtask

    task automatic expect_mem(input string name, input logic [`XLEN-1:0] addr,
                              input logic [`PREG_W-1:0] pd, input logic [`ROB_TAG_W-1:0] tag);
        bit seen;
        wait_load(name, seen);
        if (seen) begin
            check_data({name, " mem"}, 1, `XLEN'(load_mem));
            check_data({name, " fwd_valid"}, 0, `XLEN'(load_fwd_valid));
            check_data({name, " addr"}, addr, load_mem_addr);
            check_size({name, " size"}, lsq_types_pkg::SIZE_WORD,
                       lsq_types_pkg::mem_size_e'(load_mem_size));
            check_data({name, " pd"}, `XLEN'(pd), `XLEN'(load_pd));
            check_tag({name, " tag"}, tag, load_rob_tag);
        end
    endtask

    task automatic expect_store_wb(input string name, input logic [`XLEN-1:0] addr,
                                   input logic [`XLEN-1:0] data,
                                   input lsq_types_pkg::mem_size_e size);
        check_data({name, " wb"}, 1, `XLEN'(store_wb));
        check_data({name, " addr"}, addr, store_wb_addr);
        check_data({name, " data"}, data, store_wb_data);
        check_size({name, " size"}, size, lsq_types_pkg::mem_size_e'(store_wb_size));
    endtask

    task automatic test_reset_full();
        logic [`ROB_TAG_W-1:0] tags [`LSQ_DEPTH+2];
        check_data("reset ctrl", '0,
                   `XLEN'({queue_full, store_issued, store_wb, load_fwd_valid, load_mem}));
        check_data("reset wb addr", '0, store_wb_addr);
        check_data("reset wb data", '0, store_wb_data);
        check_data("reset mem addr", '0, load_mem_addr);
        check_data("reset fwd data", '0, load_fwd_data);
        check_data("reset load pd", '0, `XLEN'(load_pd));
        check_tag("reset issued tag", '0, store_issued_tag);
        check_tag("reset load tag", '0, load_rob_tag);
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            dispatch_entry(tags[i]);
        end
        check_data("full after eight", 1, `XLEN'(queue_full));
        // ninth dispatch has no room
        dispatch_entry(tags[`LSQ_DEPTH]);
        check_data("full after ninth", 1, `XLEN'(queue_full));
        issue_op(rv_isa_pkg::OP_STORE, rv_isa_pkg::F3_WORD, tags[0], '0, word_addr(), '0,
                 rand_bits(`XLEN));
        retire_entry(tags[0]);
        check_data("free after retire", 0, `XLEN'(queue_full));
        dispatch_entry(tags[`LSQ_DEPTH+1]);
        check_data("full again", 1, `XLEN'(queue_full));
        // the dropped tag owns no slot
        issue_op(rv_isa_pkg::OP_STORE, rv_isa_pkg::F3_WORD, tags[`LSQ_DEPTH], '0, word_addr(),
                 '0, rand_bits(`XLEN));
        check_data("dropped tag issue", 0, `XLEN'(store_issued));
        issue_op(rv_isa_pkg::OP_STORE, rv_isa_pkg::F3_WORD, tags[`LSQ_DEPTH+1], '0,
                 word_addr(), '0, rand_bits(`XLEN));
        check_data("late tag issue", 1, `XLEN'(store_issued));
        check_tag("late tag issue", tags[`LSQ_DEPTH+1], store_issued_tag);
        for (int i = 1; i < `LSQ_DEPTH; i++) begin
            issue_op(rv_isa_pkg::OP_STORE, rv_isa_pkg::F3_WORD, tags[i], '0, word_addr(), '0,
                     rand_bits(`XLEN));
        end
        for (int i = 1; i < `LSQ_DEPTH; i++) begin
            retire_entry(tags[i]);
        end
        retire_entry(tags[`LSQ_DEPTH+1]);
        check_data("drained", 0, `XLEN'(queue_full));
    endtask

    task automatic test_store_path();
        logic [`ROB_TAG_W-1:0] t_sw;
        logic [`ROB_TAG_W-1:0] t_sh;
        logic [`XLEN-1:0]      base;
        logic [`XLEN-1:0]      d_sw;
        logic [`XLEN-1:0]      d_sh;
        base = word_addr();
        d_sw = rand_bits(`XLEN);
        d_sh = rand_bits(`XLEN);
        dispatch_entry(t_sw);
        dispatch_entry(t_sh);
        issue_op(rv_isa_pkg::OP_STORE, rv_isa_pkg::F3_WORD, t_sw, '0, base, 32'd8, d_sw);
        check_data("store sw issued", 1, `XLEN'(store_issued));
        check_tag("store sw issued", t_sw, store_issued_tag);
        issue_op(rv_isa_pkg::OP_STORE, rv_isa_pkg::F3_HALF, t_sh, '0, base, 32'd6, d_sh);
        check_data("store sh issued", 1, `XLEN'(store_issued));
        check_tag("store sh issued", t_sh, store_issued_tag);
        retire_entry(t_sw);
        expect_store_wb("store sw", base + 32'd8, d_sw, lsq_types_pkg::SIZE_WORD);
        retire_entry(t_sh);
        expect_store_wb("store sh", base + 32'd6, d_sh, lsq_types_pkg::SIZE_HALF);
    endtask

    task automatic test_word_fwd();
        logic [`ROB_TAG_W-1:0] st;
        logic [`ROB_TAG_W-1:0] ld;
        logic [`XLEN-1:0]      base;
        logic [`XLEN-1:0]      data;
        base = word_addr();
        data = rand_bits(`XLEN);
        dispatch_entry(st);
        dispatch_entry(ld);
        issue_op(rv_isa_pkg::OP_STORE, rv_isa_pkg::F3_WORD, st, '0, base, 32'd4, data);
        issue_op(rv_isa_pkg::OP_LOAD, rv_isa_pkg::F3_WORD, ld, 7'h15, base, 32'd4, '0);
        expect_fwd("word fwd", data, 7'h15, ld);
        retire_entry(st);
        retire_entry(ld);
    endtask

    // one store followed by an lbu in each byte it covers
    task automatic byte_fwd_case(input string name, input rv_isa_pkg::rv_func3_e f3,
                                 input int nbytes, input logic [`XLEN-1:0] imm);
        logic [`ROB_TAG_W-1:0] st;
        logic [`ROB_TAG_W-1:0] ld [4];
        logic [`XLEN-1:0]      base;
        logic [`XLEN-1:0]      data;
        base = word_addr();
        data = rand_bits(`XLEN);
        dispatch_entry(st);
        for (int i = 0; i < nbytes; i++) begin
            dispatch_entry(ld[i]);
        end
        issue_op(rv_isa_pkg::OP_STORE, f3, st, '0, base, imm, data);
        for (int i = 0; i < nbytes; i++) begin
            issue_op(rv_isa_pkg::OP_LOAD, rv_isa_pkg::F3_BYTE_U, ld[i], `PREG_W'(i + 1), base,
                     imm + i, '0);
            expect_fwd(name, `XLEN'(data[8*i +: 8]), `PREG_W'(i + 1), ld[i]);
        end
        retire_entry(st);
        for (int i = 0; i < nbytes; i++) begin
            retire_entry(ld[i]);
        end
    endtask

    task automatic test_mem_order();
        logic [`ROB_TAG_W-1:0] s1;
        logic [`ROB_TAG_W-1:0] l1;
        logic [`ROB_TAG_W-1:0] s2;
        logic [`ROB_TAG_W-1:0] l2;
        logic [`XLEN-1:0]      base;
        base = word_addr();
        dispatch_entry(s1);
        dispatch_entry(l1);
        issue_op(rv_isa_pkg::OP_STORE, rv_isa_pkg::F3_WORD, s1, '0, base, '0, rand_bits(`XLEN));
        issue_op(rv_isa_pkg::OP_LOAD, rv_isa_pkg::F3_WORD, l1, 7'h21, base, 32'd16, '0);
        expect_mem("mem request", base + 32'd16, 7'h21, l1);
        retire_entry(s1);
        retire_entry(l1);
        // older store address still unknown
        dispatch_entry(s2);
        dispatch_entry(l2);
        issue_op(rv_isa_pkg::OP_LOAD, rv_isa_pkg::F3_WORD, l2, 7'h22, base, 32'd16, '0);
        expect_no_load("mem behind store", 5);
        issue_op(rv_isa_pkg::OP_STORE, rv_isa_pkg::F3_WORD, s2, '0, base, '0, rand_bits(`XLEN));
        expect_mem("mem after store issue", base + 32'd16, 7'h22, l2);
        retire_entry(s2);
        retire_entry(l2);
    endtask

    task automatic test_partial();
        logic [`ROB_TAG_W-1:0] st;
        logic [`ROB_TAG_W-1:0] ld;
        logic [`XLEN-1:0]      base;
        logic [`XLEN-1:0]      data;
        base = word_addr();
        data = rand_bits(`XLEN);
        dispatch_entry(st);
        dispatch_entry(ld);
        issue_op(rv_isa_pkg::OP_STORE, rv_isa_pkg::F3_HALF, st, '0, base, 32'd2, data);
        issue_op(rv_isa_pkg::OP_LOAD, rv_isa_pkg::F3_WORD, ld, 7'h33, base, '0, '0);
        expect_no_load("partial overlap", 6);
        retire_entry(st);
        expect_store_wb("partial sh", base + 32'd2, data, lsq_types_pkg::SIZE_HALF);
        expect_mem("partial after retire", base, 7'h33, ld);
        retire_entry(ld);
    endtask

    initial begin
        lfsr             = 32'hd249;
        next_tag         = '0;
        check_count      = 0;
        error_count      = 0;
        timeout_count    = 0;
        reset            = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_rob_tag = '0;
        issue_valid      = 1'b0;
        issue_opcode     = rv_isa_pkg::OP_LOAD;
        issue_func3      = rv_isa_pkg::F3_WORD;
        issue_rob_tag    = '0;
        issue_pd         = '0;
        issue_base       = '0;
        issue_imm        = '0;
        issue_store_data = '0;
        retire_valid     = 1'b0;
        rob_head         = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        test_reset_full();
        test_store_path();
        test_word_fwd();
        byte_fwd_case("byte fwd sw", rv_isa_pkg::F3_WORD, 4, 32'd0);
        byte_fwd_case("byte fwd sh", rv_isa_pkg::F3_HALF, 2, 32'd2);
        test_mem_order();
        test_partial();
        repeat (2) @(negedge clk);

        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
